//--- hw/scene_pkg.sv
`default_nettype none

package scene_pkg;

    // coordinate and index widths
    localparam int COORD_W = 16;
    localparam int VIDX_W  = 8;

    // memory depths
    localparam int VERT_DEPTH = 1024;
    localparam int TRI_DEPTH  = 1024;
    localparam int INST_DEPTH = 256;

    // derived address and field widths
    localparam int VADDR_W     = $clog2(VERT_DEPTH);
    localparam int TADDR_W     = $clog2(TRI_DEPTH);
    localparam int IID_W       = $clog2(INST_DEPTH);
    localparam int TCNT_W      = 8;
    localparam int XFORM_W     = 3 * COORD_W;
    localparam int INST_DESC_W = VADDR_W + TADDR_W + TCNT_W;
    localparam int INST_REC_W  = INST_DESC_W + XFORM_W;

    // host load select, code 3 is ignored
    localparam logic [1:0] SEL_VERT = 2'd0;
    localparam logic [1:0] SEL_TRI  = 2'd1;
    localparam logic [1:0] SEL_INST = 2'd2;

    typedef logic [COORD_W-1:0] coord_t;

    // x high, then y, z low
    typedef logic [3*COORD_W-1:0] vertex_t;
    typedef logic [XFORM_W-1:0]   transform_t;

    // v0 in the high byte, then v1, then v2
    typedef logic [3*VIDX_W-1:0] tri_idx_t;

    typedef logic [VADDR_W-1:0] vert_addr_t;
    typedef logic [TADDR_W-1:0] tri_addr_t;
    typedef logic [IID_W-1:0]   inst_id_t;
    typedef logic [TCNT_W-1:0]  tri_count_t;

    // vert_base, tri_base, tri_count, translation from high to low
    typedef logic [INST_REC_W-1:0] inst_rec_t;

    // host write data, narrower memories take the low bits
    typedef logic [INST_REC_W-1:0] load_word_t;

endpackage

`default_nettype wire

//--- hw/scene_read_if.sv
`timescale 1ns/100ps
`default_nettype none

interface scene_read_if;

    // read addresses from the driver
    scene_pkg::inst_id_t   inst_id;
    scene_pkg::tri_addr_t  tri_addr;
    scene_pkg::vert_addr_t vert_addr;

    // read data, one cycle behind the addresses
    scene_pkg::tri_idx_t   tri_data;
    scene_pkg::vertex_t    vert_data;

    // decoded fields of the addressed instance record
    scene_pkg::vert_addr_t vert_base;
    scene_pkg::tri_addr_t  tri_base;
    scene_pkg::tri_count_t tri_count;
    scene_pkg::transform_t transform;

    modport mem (
        input  inst_id, tri_addr, vert_addr,
        output tri_data, vert_data, vert_base, tri_base, tri_count, transform
    );

    modport drv (
        output inst_id, tri_addr, vert_addr,
        input  tri_data, vert_data, vert_base, tri_base, tri_count, transform
    );

endinterface

`default_nettype wire

//--- hw/setup_if.sv
`timescale 1ns/100ps
`default_nettype none

interface setup_if;

    // one-cycle pulse per setup
    logic                  valid;
    logic                  ready;

    // camera setups only carry a translation
    logic                  is_camera;
    scene_pkg::vertex_t    v0;
    scene_pkg::vertex_t    v1;
    scene_pkg::vertex_t    v2;
    scene_pkg::transform_t transform;

    modport src (
        output valid, is_camera, v0, v1, v2, transform,
        input  ready
    );

    modport dst (
        input  valid, is_camera, v0, v1, v2, transform,
        output ready
    );

endinterface

`default_nettype wire

//--- hw/scene_memory.sv
`timescale 1ns/100ps
`default_nettype none

module scene_memory (
    input  logic                  clk,
    input  logic                  load_en,
    input  logic [1:0]            load_sel,
    input  scene_pkg::vert_addr_t load_addr,
    input  scene_pkg::load_word_t load_data,
    scene_read_if.mem             rd
);

    // vertex and triangle storage
    scene_pkg::vertex_t    vert_ram [scene_pkg::VERT_DEPTH];
    scene_pkg::tri_idx_t   tri_ram  [scene_pkg::TRI_DEPTH];

    // instance table split into descriptor and translation halves
    logic [scene_pkg::INST_DESC_W-1:0] desc_ram  [scene_pkg::INST_DEPTH];
    scene_pkg::transform_t             xform_ram [scene_pkg::INST_DEPTH];

    logic [scene_pkg::INST_DESC_W-1:0] desc_q;
    scene_pkg::inst_id_t               load_iid;

    // instance table only sees the low address bits
    assign load_iid = load_addr[scene_pkg::IID_W-1:0];

    // host write port
    always_ff @(posedge clk) begin
        if (load_en) begin
            case (load_sel)
                scene_pkg::SEL_VERT: begin
                    vert_ram[load_addr] <= load_data[$bits(scene_pkg::vertex_t)-1:0];
                end
                scene_pkg::SEL_TRI: begin
                    tri_ram[load_addr] <= load_data[$bits(scene_pkg::tri_idx_t)-1:0];
                end
                scene_pkg::SEL_INST: begin
                    desc_ram[load_iid] <=
                        load_data[scene_pkg::INST_REC_W-1:scene_pkg::XFORM_W];
                    xform_ram[load_iid] <= load_data[scene_pkg::XFORM_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // read ports, one cycle from address to data
    always_ff @(posedge clk) begin
        rd.vert_data <= vert_ram[rd.vert_addr];
        rd.tri_data  <= tri_ram[rd.tri_addr];
        desc_q       <= desc_ram[rd.inst_id];
        rd.transform <= xform_ram[rd.inst_id];
    end

    // descriptor fields, tri_count in the low bits
    assign rd.tri_count = desc_q[scene_pkg::TCNT_W-1:0];
    assign rd.tri_base  = desc_q[scene_pkg::TCNT_W +: scene_pkg::TADDR_W];
    assign rd.vert_base = desc_q[scene_pkg::INST_DESC_W-1 -: scene_pkg::VADDR_W];

endmodule

`default_nettype wire

//--- hw/frame_driver.sv
`timescale 1ns/100ps
`default_nettype none

module frame_driver (
    input  logic                clk,
    input  logic                rst,
    input  logic                scene_loaded,
    input  scene_pkg::inst_id_t max_inst,
    input  logic                draw_start,
    output logic                draw_done,
    output logic                busy,
    scene_read_if.drv           rd,
    setup_if.src                setup
);

    typedef enum logic [3:0] {
        idle,
        load_base,
        request_tri,
        load_tri,
        wait_tri,
        wait_vert,
        capture_v0,
        capture_v1,
        capture_v2,
        output_tri,
        done
    } state_t;

    state_t                state;
    scene_pkg::inst_id_t   next_inst;
    scene_pkg::tri_count_t tri_ctr;
    scene_pkg::tri_idx_t   idx_q;
    scene_pkg::vertex_t    v0_q;
    scene_pkg::vertex_t    v1_q;
    scene_pkg::vertex_t    v2_q;
    logic                  cam_inst;
    logic                  last_tri;

    // vertex address wraps at the RAM depth
    function automatic scene_pkg::vert_addr_t vert_addr_of(
        input scene_pkg::vert_addr_t          base,
        input logic [scene_pkg::VIDX_W-1:0]   idx
    );
        return base + scene_pkg::vert_addr_t'(idx);
    endfunction

    assign cam_inst = (rd.inst_id == '0);
    assign last_tri = (tri_ctr == scene_pkg::tri_count_t'(rd.tri_count - 1'b1));
    assign busy     = (state != done);

    // instance and triangle walk, 8 cycles per triangle without stalls
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= idle;
            next_inst    <= '0;
            tri_ctr      <= '0;
            rd.inst_id   <= '0;
            rd.tri_addr  <= '0;
            rd.vert_addr <= '0;
            setup.valid  <= 1'b0;
            draw_done    <= 1'b0;
        end else if (scene_loaded) begin
            setup.valid <= 1'b0;
            case (state)
                idle: begin
                    if (setup.ready) begin
                        rd.inst_id <= next_inst;
                        next_inst  <= next_inst + 1'b1;
                        state      <= load_base;
                    end
                end
                // record data settles during this cycle
                load_base: state <= cam_inst ? output_tri : request_tri;
                request_tri: begin
                    rd.tri_addr <= rd.tri_base + scene_pkg::tri_addr_t'(tri_ctr);
                    state       <= load_tri;
                end
                load_tri: state <= wait_tri;
                wait_tri: begin
                    rd.vert_addr <= vert_addr_of(rd.vert_base,
                        rd.tri_data[3*scene_pkg::VIDX_W-1 -: scene_pkg::VIDX_W]);
                    state        <= wait_vert;
                end
                wait_vert: begin
                    rd.vert_addr <= vert_addr_of(rd.vert_base,
                        idx_q[2*scene_pkg::VIDX_W-1 -: scene_pkg::VIDX_W]);
                    state        <= capture_v0;
                end
                capture_v0: begin
                    rd.vert_addr <= vert_addr_of(rd.vert_base,
                        idx_q[scene_pkg::VIDX_W-1:0]);
                    state        <= capture_v1;
                end
                capture_v1: state <= capture_v2;
                capture_v2: state <= output_tri;
                output_tri: begin
                    if (setup.ready) begin
                        setup.valid <= 1'b1;
                        if (!cam_inst && !last_tri) begin
                            tri_ctr <= tri_ctr + 1'b1;
                            state   <= request_tri;
                        end else if (rd.inst_id == max_inst) begin
                            // last triangle of the frame, or camera only
                            tri_ctr   <= '0;
                            next_inst <= '0;
                            draw_done <= 1'b1;
                            state     <= done;
                        end else begin
                            tri_ctr <= '0;
                            state   <= idle;
                        end
                    end
                end
                done: begin
                    if (draw_start) begin
                        draw_done <= 1'b0;
                        state     <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // triangle indices, vertices and setup payload
    always_ff @(posedge clk) begin
        if (scene_loaded) begin
            case (state)
                wait_tri:   idx_q <= rd.tri_data;
                capture_v0: v0_q  <= rd.vert_data;
                capture_v1: v1_q  <= rd.vert_data;
                capture_v2: v2_q  <= rd.vert_data;
                output_tri: begin
                    if (setup.ready) begin
                        setup.is_camera <= cam_inst;
                        setup.transform <= rd.transform;
                        setup.v0        <= v0_q;
                        setup.v1        <= v1_q;
                        setup.v2        <= v2_q;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/model_translate.sv
`timescale 1ns/100ps
`default_nettype none

module model_translate (
    input  logic               clk,
    input  logic               rst,
    setup_if.dst               setup,
    input  logic               raster_ready,
    output logic               tri_valid,
    output scene_pkg::vertex_t tri_v0,
    output scene_pkg::vertex_t tri_v1,
    output scene_pkg::vertex_t tri_v2
);

    scene_pkg::transform_t camera_q;
    logic                  tri_fire;

    // per-coordinate sum, wraps at 2^16
    function automatic scene_pkg::vertex_t translate(
        input scene_pkg::vertex_t    v,
        input scene_pkg::transform_t model,
        input scene_pkg::transform_t camera
    );
        scene_pkg::vertex_t sum;
        scene_pkg::coord_t  c;
        for (int i = 0; i < 3; i++) begin
            c = v[i*scene_pkg::COORD_W +: scene_pkg::COORD_W]
              + model[i*scene_pkg::COORD_W +: scene_pkg::COORD_W]
              + camera[i*scene_pkg::COORD_W +: scene_pkg::COORD_W];
            sum[i*scene_pkg::COORD_W +: scene_pkg::COORD_W] = c;
        end
        return sum;
    endfunction

    assign setup.ready = raster_ready;
    assign tri_fire    = setup.valid && !setup.is_camera;

    // camera translation held until the next camera setup
    always_ff @(posedge clk) begin
        if (setup.valid && setup.is_camera) begin
            camera_q <= setup.transform;
        end
    end

    always_ff @(posedge clk) begin
        if (tri_fire) begin
            tri_v0 <= translate(setup.v0, setup.transform, camera_q);
            tri_v1 <= translate(setup.v1, setup.transform, camera_q);
            tri_v2 <= translate(setup.v2, setup.transform, camera_q);
        end
    end

    // one pulse per triangle setup
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= tri_fire;
        end
    end

endmodule

`default_nettype wire

//--- hw/frame_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fetch_top (
    input  logic                  clk,
    input  logic                  rst,

    // host load port
    input  logic                  load_en,
    input  logic [1:0]            load_sel,
    input  scene_pkg::vert_addr_t load_addr,
    input  scene_pkg::load_word_t load_data,

    // frame control
    input  logic                  scene_loaded,
    input  scene_pkg::inst_id_t   max_inst,
    input  logic                  draw_start,
    input  logic                  raster_ready,

    // rasterizer side
    output logic                  tri_valid,
    output scene_pkg::vertex_t    tri_v0,
    output scene_pkg::vertex_t    tri_v1,
    output scene_pkg::vertex_t    tri_v2,
    output logic                  draw_done,
    output logic                  busy
);

    scene_read_if rd_bus ();
    setup_if      setup_bus ();

    scene_memory u_scene_memory (
        .clk       (clk),
        .load_en   (load_en),
        .load_sel  (load_sel),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd        (rd_bus.mem)
    );

    frame_driver u_frame_driver (
        .clk          (clk),
        .rst          (rst),
        .scene_loaded (scene_loaded),
        .max_inst     (max_inst),
        .draw_start   (draw_start),
        .draw_done    (draw_done),
        .busy         (busy),
        .rd           (rd_bus.drv),
        .setup        (setup_bus.src)
    );

    model_translate u_model_translate (
        .clk          (clk),
        .rst          (rst),
        .setup        (setup_bus.dst),
        .raster_ready (raster_ready),
        .tri_valid    (tri_valid),
        .tri_v0       (tri_v0),
        .tri_v1       (tri_v1),
        .tri_v2       (tri_v2)
    );

endmodule

`default_nettype wire

//--- sim/frame_fetch_tb.sv
`timescale 1ns/100ps
`default_nettype none

module frame_fetch_tb;

    localparam int                    NUM_INST   = 6;
    localparam int                    MARGIN     = 200;
    localparam scene_pkg::transform_t NEW_CAMERA = 48'h0040_ff80_1000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  load_en;
    logic [1:0]            load_sel;
    scene_pkg::vert_addr_t load_addr;
    scene_pkg::load_word_t load_data;
    logic                  scene_loaded;
    scene_pkg::inst_id_t   max_inst;
    logic                  draw_start;
    logic                  raster_ready;
    logic                  tri_valid;
    scene_pkg::vertex_t    tri_v0;
    scene_pkg::vertex_t    tri_v1;
    scene_pkg::vertex_t    tri_v2;
    logic                  draw_done;
    logic                  busy;

    // copy of what the host loads
    scene_pkg::vertex_t    vert_mem   [scene_pkg::VERT_DEPTH];
    scene_pkg::tri_idx_t   tri_mem    [scene_pkg::TRI_DEPTH];
    scene_pkg::vert_addr_t inst_vbase [NUM_INST+1];
    scene_pkg::tri_addr_t  inst_tbase [NUM_INST+1];
    scene_pkg::tri_count_t inst_tcnt  [NUM_INST+1];
    scene_pkg::transform_t inst_xform [NUM_INST+1];

    logic [143:0] exp_q [$];
    logic [31:0]  lfsr = 32'hc8ca;
    logic         ready_random;
    int           watch_cycles = 0;

    frame_fetch_top UUT (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_sel     (load_sel),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .scene_loaded (scene_loaded),
        .max_inst     (max_inst),
        .draw_start   (draw_start),
        .raster_ready (raster_ready),
        .tri_valid    (tri_valid),
        .tri_v0       (tri_v0),
        .tri_v1       (tri_v1),
        .tri_v2       (tri_v2),
        .draw_done    (draw_done),
        .busy         (busy)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // galois shift stepped once per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // raw vertex plus model and camera offsets per coordinate mod 2^16
    function automatic scene_pkg::vertex_t expected_vertex(input scene_pkg::vertex_t v,
            input scene_pkg::transform_t model, input scene_pkg::transform_t cam);
        scene_pkg::vertex_t r;
        for (int c = 0; c < 3; c++) begin
            r[c*16 +: 16] = v[c*16 +: 16] + model[c*16 +: 16] + cam[c*16 +: 16];
        end
        return r;
    endfunction

    task automatic compare_vertex(input string name, input scene_pkg::vertex_t got,
            input scene_pkg::vertex_t exp);
        assert (got == exp)
            else report_failure($sformatf("[FAIL] %0t %s: got %h expected %h",
                $time, name, got, exp));
    endtask

    task automatic make_scene();
        int total;
        total = 0;
        for (int a = 0; a < scene_pkg::VERT_DEPTH; a++) begin
            vert_mem[a] = scene_pkg::vertex_t'(take_bits(48));
        end
        for (int a = 0; a < scene_pkg::TRI_DEPTH; a++) begin
            tri_mem[a] = scene_pkg::tri_idx_t'(take_bits(24));
        end
        for (int i = 0; i <= NUM_INST; i++) begin
            inst_vbase[i] = scene_pkg::vert_addr_t'(take_bits(10));
            inst_tbase[i] = scene_pkg::tri_addr_t'(take_bits(10));
            inst_tcnt[i]  = scene_pkg::tri_count_t'(take_bits(2) + 1);
            inst_xform[i] = scene_pkg::transform_t'(take_bits(48));
            if (i > 0) begin
                total += int'(inst_tcnt[i]);
            end
        end
        // base near the top so indices wrap past the end of the vertex RAM
        inst_vbase[1] = 10'd1000;
        watch_cycles = 16 + scene_pkg::VERT_DEPTH + scene_pkg::TRI_DEPTH + NUM_INST + 8
            + 3 * MARGIN + 2 * 40 * total;
    endtask

    task automatic host_write(input logic [1:0] sel, input scene_pkg::vert_addr_t addr,
            input scene_pkg::load_word_t data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_sel  <= sel;
        load_addr <= addr;
        load_data <= data;
    endtask

    task automatic write_instance(input int i);
        host_write(scene_pkg::SEL_INST, scene_pkg::vert_addr_t'(i),
            {inst_vbase[i], inst_tbase[i], inst_tcnt[i], inst_xform[i]});
    endtask

    task automatic load_scene();
        for (int a = 0; a < scene_pkg::VERT_DEPTH; a++) begin
            host_write(scene_pkg::SEL_VERT, scene_pkg::vert_addr_t'(a),
                scene_pkg::load_word_t'(vert_mem[a]));
        end
        for (int a = 0; a < scene_pkg::TRI_DEPTH; a++) begin
            host_write(scene_pkg::SEL_TRI, scene_pkg::vert_addr_t'(a),
                scene_pkg::load_word_t'(tri_mem[a]));
        end
        for (int i = 0; i <= NUM_INST; i++) begin
            write_instance(i);
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    // instances and triangles in ascending order
    task automatic build_expected(input int last_inst);
        scene_pkg::tri_addr_t  taddr;
        scene_pkg::vert_addr_t vaddr;
        scene_pkg::tri_idx_t   idx;
        scene_pkg::vertex_t    v [3];
        exp_q.delete();
        for (int i = 1; i <= last_inst; i++) begin
            for (int t = 0; t < int'(inst_tcnt[i]); t++) begin
                taddr = inst_tbase[i] + scene_pkg::tri_addr_t'(t);
                idx   = tri_mem[taddr];
                for (int k = 0; k < 3; k++) begin
                    vaddr = inst_vbase[i] + scene_pkg::vert_addr_t'(idx[(2-k)*8 +: 8]);
                    v[k]  = expected_vertex(vert_mem[vaddr], inst_xform[i], inst_xform[0]);
                end
                exp_q.push_back({v[0], v[1], v[2]});
            end
        end
    endtask

    task automatic await_frame();
        do begin
            @(posedge clk);
        end while (!draw_done);
        // last triangle leaves model_translate a cycle after draw_done
        repeat (2) @(posedge clk);
        assert (exp_q.size() == 0)
            else report_failure($sformatf("[FAIL] %0t triangles left: got %0d expected 0",
                $time, exp_q.size()));
    endtask

    task automatic restart_frame(input scene_pkg::inst_id_t last_inst);
        build_expected(int'(last_inst));
        @(posedge clk);
        max_inst   <= last_inst;
        draw_start <= 1'b1;
        @(posedge clk);
        draw_start <= 1'b0;
    endtask

    always @(posedge clk) begin
        if (ready_random) begin
            raster_ready <= (take_bits(2) != 0);
        end else begin
            raster_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin : scoreboard
        logic [143:0] exp_tri;
        if (!rst && tri_valid) begin
            assert (exp_q.size() != 0) begin
                exp_tri = exp_q.pop_front();
                compare_vertex("tri_v0", tri_v0, exp_tri[143:96]);
                compare_vertex("tri_v1", tri_v1, exp_tri[95:48]);
                compare_vertex("tri_v2", tri_v2, exp_tri[47:0]);
            end else begin
                report_failure("tri_valid pulsed with no triangle left in the frame");
            end
        end
    end

    // quiet until the scene is loaded
    assert property (@(posedge clk) !scene_loaded |-> !tri_valid && !draw_done && busy)
        else report_failure($sformatf(
            "[FAIL] %0t tri_valid/draw_done/busy: got %b/%b/%b expected 0/0/1",
            $time, $sampled(tri_valid), $sampled(draw_done), $sampled(busy)));

    assert property (@(posedge clk) disable iff (rst) busy == !draw_done)
        else report_failure($sformatf("[FAIL] %0t busy: got %b expected %b",
            $time, $sampled(busy), !$sampled(draw_done)));

    // tri_valid comes two cycles after a ready cycle
    assert property (@(posedge clk) disable iff (rst) tri_valid |-> $past(raster_ready, 2))
        else report_failure($sformatf(
            "[FAIL] %0t raster_ready two cycles before tri_valid: got 0 expected 1", $time));

    assert property (@(posedge clk) disable iff (rst)
            scene_loaded && draw_start && draw_done |=> !draw_done)
        else report_failure($sformatf(
            "[FAIL] %0t draw_done after draw_start: got 1 expected 0", $time));

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        report_failure("timeout: the frames did not finish in time");
    end

    initial begin : stimulus
        rst          = 1'b1;
        load_en      = 1'b0;
        load_sel     = '0;
        load_addr    = '0;
        load_data    = '0;
        scene_loaded = 1'b0;
        max_inst     = '0;
        draw_start   = 1'b0;
        raster_ready = 1'b1;
        ready_random = 1'b0;
        make_scene();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        load_scene();
        // first frame starts straight from reset
        build_expected(NUM_INST);
        @(posedge clk);
        max_inst     <= scene_pkg::inst_id_t'(NUM_INST);
        scene_loaded <= 1'b1;
        ready_random <= 1'b1;
        await_frame();
        // second frame with a moved camera
        inst_xform[0] = NEW_CAMERA;
        write_instance(0);
        @(posedge clk);
        load_en <= 1'b0;
        restart_frame(scene_pkg::inst_id_t'(NUM_INST));
        await_frame();
        // camera only
        restart_frame('0);
        await_frame();
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- frame_fetch.f
hw/scene_pkg.sv
hw/scene_read_if.sv
hw/setup_if.sv
hw/scene_memory.sv
hw/frame_driver.sv
hw/model_translate.sv
hw/frame_fetch_top.sv
sim/frame_fetch_tb.sv

//--- Bender.yml
package:
  name: frame_fetch

sources:
  - hw/scene_pkg.sv
  - hw/scene_read_if.sv
  - hw/setup_if.sv
  - hw/scene_memory.sv
  - hw/frame_driver.sv
  - hw/model_translate.sv
  - hw/frame_fetch_top.sv
  - target: test
    files:
      - sim/frame_fetch_tb.sv
